// File: files.f
common/rob_pkg.sv
rob/rob_status.sv
rob/rob_field_ram.sv
hw/rob_alloc.sv
hw/rob_recovery_fsm.sv
hw/rob_top.sv
bench/rob_checker.sv
bench/rob_tb_checks.sv
bench/rob_tb.sv

// File: bench/rob_tb.sv
// reorder buffer testbench
`timescale 1ns/10ps
module rob_tb;
    import rob_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_RAND     = 300;
    localparam int N_FULL     = 24;
    localparam int N_MIS      = 400;
    localparam int DRAIN_MAX  = 200;
    localparam int RUN_CYCLES = 6 + 2 * N_RAND + N_FULL + N_MIS + 4 * DRAIN_MAX;

    // model view of one live entry
    typedef struct packed {
        rob_ptr_t            addr;
        logic [ADDR_LEN-1:0] pc;
        logic [REG_SEL-1:0]  dst;
        logic                dst_valid;
        logic                is_store;
        logic                is_branch;
        logic                pred_taken;
        logic [BHR_LEN-1:0]  bhr;
        logic                fin;
        logic                taken;
        logic [ADDR_LEN-1:0] target;
    } entry_t;

    logic                 clk;
    logic                 reset;
    dp_slot_t [1:0]       dp;
    fin_t [NUM_FIN-1:0]   fin;
    br_fin_t              br_fin;
    logic                 dp_ready;
    rob_ptr_t [1:0]       dp_addr;
    arf_wr_t [1:0]        arf_wr;
    logic [1:0]           store_commit;
    br_commit_t           br_commit;
    redirect_t            redirect;

    entry_t              rob_q[$];
    rob_ptr_t            dead_q[$];
    logic [31:0]         lfsr;
    rob_ptr_t            head_m;
    rob_ptr_t            tail_m;
    int                  block_cnt;
    logic                flush_next;
    logic [ADDR_LEN-1:0] redirect_target;
    logic                use_branch;
    logic                use_store;
    logic                allow_mis;
    logic                hold_fin;
    logic                pair_dispatch;
    logic                dispatch_on;
    int                  adj_branch_seen;
    int                  redirect_seen;
    int                  not_ready_seen;

    rob_top i_rob_top (
        .clk            (clk),
        .reset          (reset),
        .dp_i           (dp),
        .fin_i          (fin),
        .br_fin_i       (br_fin),
        .dp_ready_o     (dp_ready),
        .dp_addr_o      (dp_addr),
        .arf_wr_o       (arf_wr),
        .store_commit_o (store_commit),
        .br_commit_o    (br_commit),
        .redirect_o     (redirect)
    );

    rob_tb_checks i_checks ();

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic model_ready();
        return block_cnt == 0 && rob_q.size() <= ROB_NUM - 2;
    endfunction

    function automatic logic addr_live(input rob_ptr_t a);
        foreach (rob_q[i]) begin
            if (rob_q[i].addr == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic drive_inputs();
        dp_slot_t [1:0]     s;
        fin_t [NUM_FIN-1:0] f;
        br_fin_t            b;
        int                 port;
        logic               mis;
        s    = '0;
        f    = '0;
        b    = '0;
        port = 0;
        for (int k = 0; k < 2; k++) begin
            s[k].valid      = dispatch_on && model_ready() && (pair_dispatch || rand_bits(1));
            s[k].pc         = rand_bits(ADDR_LEN);
            s[k].dst        = rand_bits(REG_SEL);
            s[k].bhr        = rand_bits(BHR_LEN);
            s[k].is_branch  = use_branch && rand_bits(2) == 0;
            s[k].is_store   = use_store && !s[k].is_branch && rand_bits(2) == 0;
            s[k].dst_valid  = !s[k].is_branch && !s[k].is_store && rand_bits(1);
            s[k].pred_taken = rand_bits(1);
        end
        if (!hold_fin) begin
            foreach (rob_q[i]) begin
                if (!rob_q[i].fin && rand_bits(1)) begin
                    if (rob_q[i].is_branch && !b.valid) begin
                        mis      = allow_mis && rand_bits(3) == 7;
                        b.valid  = 1'b1;
                        b.addr   = rob_q[i].addr;
                        b.taken  = rob_q[i].pred_taken ^ mis;
                        b.target = rand_bits(ADDR_LEN);
                    end else if (!rob_q[i].is_branch && port < NUM_FIN) begin
                        f[port].valid = 1'b1;
                        f[port].addr  = rob_q[i].addr;
                        port++;
                    end
                end
            end
        end
        // late strobes for flushed entries
        if (block_cnt > 0 && dead_q.size() > 0) begin
            f[NUM_FIN-1].valid = 1'b1;
            f[NUM_FIN-1].addr  = dead_q[0];
            b.valid            = 1'b1;
            b.addr             = dead_q[dead_q.size()-1];
            b.taken            = 1'b1;
            b.target           = rand_bits(ADDR_LEN);
        end
        dp     <= s;
        fin    <= f;
        br_fin <= b;
    endtask

    task automatic check_cycle();
        logic       flushing;
        logic       mis;
        logic       brv;
        logic [1:0] commit;
        logic [1:0] stores;
        entry_t     be;
        entry_t     e;
        flushing  = flush_next;
        commit[0] = !flushing && rob_q.size() > 0 && rob_q[0].fin;
        commit[1] = commit[0] && rob_q.size() > 1 && rob_q[1].fin
                    && !(rob_q[0].is_branch && rob_q[1].is_branch)
                    && !(rob_q[0].is_branch && rob_q[0].taken != rob_q[0].pred_taken);
        stores = '0;
        brv    = 1'b0;
        be     = '0;
        i_checks.check_value("dp_ready_o", model_ready(), dp_ready);
        if (!dp_ready) not_ready_seen++;
        for (int k = 0; k < 2; k++) begin
            if (commit[k]) begin
                i_checks.check_value($sformatf("arf_wr_o[%0d].we", k),
                                     rob_q[k].dst_valid, arf_wr[k].we);
                if (rob_q[k].dst_valid) begin
                    i_checks.check_value($sformatf("arf_wr_o[%0d].dst", k),
                                         rob_q[k].dst, arf_wr[k].dst);
                end
                stores += 2'(rob_q[k].is_store);
                if (rob_q[k].is_branch) begin
                    brv = 1'b1;
                    be  = rob_q[k];
                end
            end else begin
                i_checks.check_value($sformatf("arf_wr_o[%0d].we", k), 0, arf_wr[k].we);
            end
        end
        i_checks.check_value("store_commit_o", stores, store_commit);
        i_checks.check_value("br_commit_o.valid", brv, br_commit.valid);
        if (brv) begin
            i_checks.check_value("br_commit_o.pc", be.pc, br_commit.pc);
            i_checks.check_value("br_commit_o.bhr", be.bhr, br_commit.bhr);
            i_checks.check_value("br_commit_o.taken", be.taken, br_commit.taken);
            i_checks.check_value("br_commit_o.target", be.target, br_commit.target);
        end
        if (commit[0] && rob_q.size() > 1 && rob_q[0].is_branch && rob_q[1].is_branch
            && rob_q[1].fin) begin
            adj_branch_seen++;
        end
        i_checks.check_value("redirect_o.valid", flushing, redirect.valid);
        if (flushing) begin
            i_checks.check_value("redirect_o.target", redirect_target, redirect.target);
            redirect_seen++;
        end
        mis = brv && be.taken != be.pred_taken;
        if (flushing) begin
            dead_q.delete();
            foreach (rob_q[i]) dead_q.push_back(rob_q[i].addr);
            rob_q.delete();
            tail_m     = head_m;
            flush_next = 1'b0;
        end else begin
            foreach (rob_q[i]) begin
                for (int p = 0; p < NUM_FIN; p++) begin
                    if (fin[p].valid && fin[p].addr == rob_q[i].addr) rob_q[i].fin = 1'b1;
                end
                if (br_fin.valid && br_fin.addr == rob_q[i].addr) begin
                    rob_q[i].fin    = 1'b1;
                    rob_q[i].taken  = br_fin.taken;
                    rob_q[i].target = br_fin.target;
                end
            end
            for (int k = 0; k < 2; k++) begin
                if (commit[k]) begin
                    void'(rob_q.pop_front());
                    head_m++;
                end
            end
            for (int k = 0; k < 2; k++) begin
                if (dp[k].valid) begin
                    i_checks.check_value($sformatf("dp_addr_o[%0d]", k), tail_m, dp_addr[k]);
                    i_checks.check_true(!addr_live(dp_addr[k]),
                                        "a dispatch address is still held by a live entry");
                    e            = '0;
                    e.addr       = tail_m;
                    e.pc         = dp[k].pc;
                    e.dst        = dp[k].dst;
                    e.dst_valid  = dp[k].dst_valid;
                    e.is_store   = dp[k].is_store;
                    e.is_branch  = dp[k].is_branch;
                    e.pred_taken = dp[k].pred_taken;
                    e.bhr        = dp[k].bhr;
                    rob_q.push_back(e);
                    tail_m++;
                end
            end
            flush_next = mis;
        end
        if (block_cnt > 0) block_cnt--;
        if (mis) begin
            block_cnt       = 1 + REFILL_CYCLES;
            redirect_target = be.target;
        end
    endtask

    task automatic run_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            check_cycle();
        end
    endtask

    // stop dispatch and wait for the model queue to empty
    task automatic drain();
        int guard;
        guard       = 0;
        dispatch_on = 1'b0;
        while ((rob_q.size() > 0 || block_cnt > 0 || flush_next) && guard < DRAIN_MAX) begin
            run_cycles(1);
            guard++;
        end
        i_checks.check_true(rob_q.size() == 0, "the ROB did not drain in time");
        dispatch_on = 1'b1;
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        dp              = '0;
        fin             = '0;
        br_fin          = '0;
        lfsr            = 32'h4324_a034;
        head_m          = '0;
        tail_m          = '0;
        block_cnt       = 0;
        flush_next      = 1'b0;
        redirect_target = '0;
        use_branch      = 1'b0;
        use_store       = 1'b0;
        allow_mis       = 1'b0;
        hold_fin        = 1'b0;
        pair_dispatch   = 1'b0;
        dispatch_on     = 1'b1;
        adj_branch_seen = 0;
        redirect_seen   = 0;
        not_ready_seen  = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_cycle();
        i_checks.end_test("reset state");

        run_cycles(N_RAND);
        drain();
        i_checks.end_test("in-order commit");

        use_branch = 1'b1;
        use_store  = 1'b1;
        run_cycles(N_RAND);
        drain();
        i_checks.check_true(adj_branch_seen > 0, "no adjacent finished branch pair was seen");
        i_checks.end_test("store and branch reporting");

        hold_fin       = 1'b1;
        pair_dispatch  = 1'b1;
        not_ready_seen = 0;
        run_cycles(N_FULL);
        i_checks.check_true(not_ready_seen > 0, "dp_ready_o never fell with the ROB full");
        hold_fin      = 1'b0;
        pair_dispatch = 1'b0;
        drain();
        i_checks.check_true(dp_ready === 1'b1, "dp_ready_o did not come back after release");
        i_checks.end_test("full ROB back-pressure");

        allow_mis = 1'b1;
        run_cycles(N_MIS);
        drain();
        i_checks.check_true(redirect_seen > 0, "no mispredicted branch reached commit");
        i_checks.end_test("mispredict recovery");

        $display("tests passed: %0d, failed: %0d, bound assertion failures: %0d",
                 i_checks.passed, i_checks.failed, i_rob_top.u_status.i_rob_checker.fails);
        if (i_checks.failed == 0 && i_rob_top.u_status.i_rob_checker.fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the test lengths
    initial begin
        #((RUN_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: bench/rob_tb_checks.sv
// testbench result checks
`timescale 1ns/10ps
module rob_tb_checks;

    int errors;
    int passed;
    int failed;

    initial begin
        errors = 0;
        passed = 0;
        failed = 0;
    end

    // compare one DUT value with the model
    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp === act) else begin
            $display("error %s expected 0x%0h actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // one line per finished test
    task automatic end_test(input string name);
        if (errors == 0) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d errors", name, errors);
            failed++;
        end
        errors = 0;
    endtask

endmodule

// File: bench/rob_checker.sv
// rob status invariants
`timescale 1ns/10ps
module rob_checker (
    input logic                        clk,
    input logic                        reset,
    input rob_pkg::rob_ptr_t           head_i,
    input logic [rob_pkg::ROB_NUM-1:0] valid_q,
    input logic [rob_pkg::ROB_NUM-1:0] finish_q
);
    import rob_pkg::*;

    logic [ROB_NUM-1:0] live_rot;
    logic [ROB_NUM-1:0] live_inc;

    int fails = 0;

    // valid bits rotated so the head sits at bit 0
    assign live_rot = (valid_q >> head_i) | (valid_q << (ROB_NUM - head_i));
    assign live_inc = live_rot + 1'b1;

    // live entries form one unbroken run from the head
    slot_order: assert property (@(posedge clk) disable iff (reset)
        (live_rot & live_inc) == '0)
        else begin
            $error("an entry retired ahead of an older live entry");
            fails++;
        end

    // finish bits never outlive the entry
    finish_valid: assert property (@(posedge clk) disable iff (reset)
        (finish_q & ~valid_q) == '0)
        else begin
            $error("entry finished while not valid");
            fails++;
        end

endmodule

bind rob_status rob_checker i_rob_checker (.*);

// File: hw/rob_top.sv
// reorder buffer subsystem top
`timescale 1ns/10ps
module rob_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  rob_pkg::dp_slot_t [1:0]              dp_i,
    input  rob_pkg::fin_t [rob_pkg::NUM_FIN-1:0] fin_i,
    input  rob_pkg::br_fin_t                     br_fin_i,
    output logic                                 dp_ready_o,
    output rob_pkg::rob_ptr_t [1:0]              dp_addr_o,
    output rob_pkg::arf_wr_t [1:0]               arf_wr_o,
    output logic [1:0]                           store_commit_o,
    output rob_pkg::br_commit_t                  br_commit_o,
    output rob_pkg::redirect_t                   redirect_o
);
    import rob_pkg::*;

    rob_ptr_t          head;
    rob_ptr_t [1:0]    rd_addr;
    logic [1:0]        dp_we;
    logic [1:0]        commit_num;
    logic [1:0]        dst_valid_sel;
    logic [1:0]        branch_slot;
    logic              mispredict;
    logic              flush;
    logic              dispatch_block;
    logic              br_sel;
    dp_payload_t [1:0] dp_wdata;
    dp_payload_t [1:0] dp_rdata;
    br_payload_t [1:0] br_rdata;
    br_payload_t [0:0] br_wdata;

    rob_alloc u_alloc (
        .clk              (clk),
        .reset            (reset),
        .dp_valid_i       ({dp_i[1].valid, dp_i[0].valid}),
        .commit_num_i     (commit_num),
        .flush_i          (flush),
        .dispatch_block_i (dispatch_block),
        .dp_ready_o       (dp_ready_o),
        .dp_addr_o        (dp_addr_o),
        .head_o           (head),
        .dp_we_o          (dp_we)
    );

    rob_status u_status (
        .clk             (clk),
        .reset           (reset),
        .head_i          (head),
        .dp_we_i         (dp_we),
        .dp_addr_i       (dp_addr_o),
        .dp_i            (dp_i),
        .fin_i           (fin_i),
        .br_fin_i        (br_fin_i),
        .flush_i         (flush),
        .commit_en_o     (),
        .commit_num_o    (commit_num),
        .dst_valid_sel_o (dst_valid_sel),
        .store_commit_o  (store_commit_o),
        .branch_slot_o   (branch_slot),
        .mispredict_o    (mispredict),
        .rd_addr_o       (rd_addr)
    );

    // per-slot payload taken from the dispatch bundle
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            dp_wdata[k].pc        = dp_i[k].pc;
            dp_wdata[k].dst       = dp_i[k].dst;
            dp_wdata[k].dst_valid = dp_i[k].dst_valid;
            dp_wdata[k].bhr       = dp_i[k].bhr;
        end
    end

    rob_field_ram #(.entry_t(dp_payload_t), .NUM_WR(2)) u_dp_ram (
        .clk     (clk),
        .we_i    (dp_we),
        .waddr_i (dp_addr_o),
        .wdata_i (dp_wdata),
        .raddr_i (rd_addr),
        .rdata_o (dp_rdata)
    );

    assign br_wdata[0].taken  = br_fin_i.taken;
    assign br_wdata[0].target = br_fin_i.target;

    rob_field_ram #(.entry_t(br_payload_t), .NUM_WR(1)) u_br_ram (
        .clk     (clk),
        .we_i    (br_fin_i.valid),
        .waddr_i (br_fin_i.addr),
        .wdata_i (br_wdata),
        .raddr_i (rd_addr),
        .rdata_o (br_rdata)
    );

    rob_recovery_fsm u_recovery (
        .clk              (clk),
        .reset            (reset),
        .mispredict_i     (mispredict),
        .target_i         (br_rdata[br_sel].target),
        .flush_o          (flush),
        .dispatch_block_o (dispatch_block),
        .redirect_o       (redirect_o)
    );

    // at most one branch commits, pick its slot
    assign br_sel = branch_slot[1];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            arf_wr_o[k].we  = dst_valid_sel[k];
            arf_wr_o[k].dst = dp_rdata[k].dst;
        end
    end

    assign br_commit_o.valid  = |branch_slot;
    assign br_commit_o.pc     = dp_rdata[br_sel].pc;
    assign br_commit_o.bhr    = dp_rdata[br_sel].bhr;
    assign br_commit_o.taken  = br_rdata[br_sel].taken;
    assign br_commit_o.target = br_rdata[br_sel].target;

endmodule

// File: hw/rob_recovery_fsm.sv
// mispredict recovery sequencer
`timescale 1ns/10ps
module rob_recovery_fsm (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           mispredict_i,
    input  logic [rob_pkg::ADDR_LEN-1:0]   target_i,
    output logic                           flush_o,
    output logic                           dispatch_block_o,
    output rob_pkg::redirect_t             redirect_o
);
    import rob_pkg::*;

    typedef enum logic [1:0] {
        RUN,
        FLUSH,
        REFILL
    } state_t;

    state_t              state_q;
    logic [REFILL_W-1:0] cnt_q;
    logic [ADDR_LEN-1:0] target_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= RUN;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                RUN: begin
                    if (mispredict_i) begin
                        state_q <= FLUSH;
                    end
                end
                FLUSH: begin
                    state_q <= REFILL;
                    cnt_q   <= REFILL_W'(REFILL_CYCLES);
                end
                REFILL: begin
                    // frontend refetch window
                    if (cnt_q == REFILL_W'(1)) begin
                        state_q <= RUN;
                    end
                    cnt_q <= cnt_q - 1'b1;
                end
                default: state_q <= RUN;
            endcase
        end
    end

    // capture the redirect address at the commit of the bad branch
    always_ff @(posedge clk) begin
        if (state_q == RUN && mispredict_i) begin
            target_q <= target_i;
        end
    end

    assign flush_o           = (state_q == FLUSH);
    assign dispatch_block_o  = (state_q != RUN);
    assign redirect_o.valid  = (state_q == FLUSH);
    assign redirect_o.target = target_q;

endmodule

// File: hw/rob_alloc.sv
// reorder buffer entry allocator
`timescale 1ns/10ps
module rob_alloc (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [1:0]              dp_valid_i,
    input  logic [1:0]              commit_num_i,
    input  logic                    flush_i,
    input  logic                    dispatch_block_i,
    output logic                    dp_ready_o,
    output rob_pkg::rob_ptr_t [1:0] dp_addr_o,
    output rob_pkg::rob_ptr_t       head_o,
    output logic [1:0]              dp_we_o
);
    import rob_pkg::*;

    rob_ptr_t           head_q;
    rob_ptr_t           tail_q;
    logic [ROB_SEL:0]   count_q;
    rob_ptr_t           head_next;
    logic [1:0]         num_acc;

    // need room for a full pair
    assign dp_ready_o = ~dispatch_block_i & (count_q <= (ROB_SEL + 1)'(ROB_NUM - 2));
    assign dp_we_o    = dp_valid_i & {2{dp_ready_o}};
    assign num_acc    = 2'(dp_we_o[0]) + 2'(dp_we_o[1]);

    // compacted, a lone slot 1 takes the tail
    assign dp_addr_o[0] = tail_q;
    assign dp_addr_o[1] = tail_q + ROB_SEL'(dp_valid_i[0]);

    assign head_next = head_q + ROB_SEL'(commit_num_i);
    assign head_o    = head_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q <= head_next;
            if (flush_i) begin
                // drop everything younger than the committed head
                tail_q  <= head_next;
                count_q <= '0;
            end else begin
                tail_q  <= tail_q + ROB_SEL'(num_acc);
                count_q <= count_q + (ROB_SEL + 1)'(num_acc)
                           - (ROB_SEL + 1)'(commit_num_i);
            end
        end
    end

endmodule

// File: rob/rob_field_ram.sv
// multi-port entry payload storage
`timescale 1ns/10ps
module rob_field_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  NUM_WR  = 1
) (
    input  logic                               clk,
    input  logic [NUM_WR-1:0]                  we_i,
    input  rob_pkg::rob_ptr_t [NUM_WR-1:0]     waddr_i,
    input  entry_t [NUM_WR-1:0]                wdata_i,
    input  rob_pkg::rob_ptr_t [1:0]            raddr_i,
    output entry_t [1:0]                       rdata_o
);
    import rob_pkg::*;

    entry_t mem [ROB_NUM];

    // later ports overwrite earlier ones on the same address
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_WR; p++) begin
            if (we_i[p]) begin
                mem[waddr_i[p]] <= wdata_i[p];
            end
        end
    end

    // asynchronous reads for the two commit slots
    assign rdata_o[0] = mem[raddr_i[0]];
    assign rdata_o[1] = mem[raddr_i[1]];

endmodule

// File: rob/rob_status.sv
// reorder buffer entry status and commit select
`timescale 1ns/10ps
module rob_status (
    input  logic                                 clk,
    input  logic                                 reset,
    input  rob_pkg::rob_ptr_t                    head_i,
    input  logic [1:0]                           dp_we_i,
    input  rob_pkg::rob_ptr_t [1:0]              dp_addr_i,
    input  rob_pkg::dp_slot_t [1:0]              dp_i,
    input  rob_pkg::fin_t [rob_pkg::NUM_FIN-1:0] fin_i,
    input  rob_pkg::br_fin_t                     br_fin_i,
    input  logic                                 flush_i,
    output logic [1:0]                           commit_en_o,
    output logic [1:0]                           commit_num_o,
    output logic [1:0]                           dst_valid_sel_o,
    output logic [1:0]                           store_commit_o,
    output logic [1:0]                           branch_slot_o,
    output logic                                 mispredict_o,
    output rob_pkg::rob_ptr_t [1:0]              rd_addr_o
);
    import rob_pkg::*;

    logic [ROB_NUM-1:0] valid_q;
    logic [ROB_NUM-1:0] finish_q;
    logic [ROB_NUM-1:0] store_q;
    logic [ROB_NUM-1:0] branch_q;
    logic [ROB_NUM-1:0] pred_q;
    logic [ROB_NUM-1:0] taken_q;
    logic [ROB_NUM-1:0] dstv_q;

    rob_ptr_t h0;
    rob_ptr_t h1;
    logic     c0;
    logic     c1;
    logic     mis0;
    logic     mis1;

    // entry count is a power of two, so the add wraps
    assign h0 = head_i;
    assign h1 = head_i + 1'b1;
    assign rd_addr_o[0] = h0;
    assign rd_addr_o[1] = h1;

    assign mis0 = branch_q[h0] & (taken_q[h0] != pred_q[h0]);
    assign mis1 = branch_q[h1] & (taken_q[h1] != pred_q[h1]);

    // no commit while the flush is in progress
    assign c0 = valid_q[h0] & finish_q[h0] & ~flush_i;
    // slot 1 only behind slot 0, one branch per cycle, nothing past a mispredict
    assign c1 = c0 & valid_q[h1] & finish_q[h1] & ~(branch_q[h0] & branch_q[h1]) & ~mis0;

    assign commit_en_o     = {c1, c0};
    assign commit_num_o    = 2'(c0) + 2'(c1);
    assign dst_valid_sel_o = {c1 & dstv_q[h1], c0 & dstv_q[h0]};
    assign store_commit_o  = 2'(c0 & store_q[h0]) + 2'(c1 & store_q[h1]);
    assign branch_slot_o   = {c1 & branch_q[h1], c0 & branch_q[h0]};
    assign mispredict_o    = (c0 & mis0) | (c1 & mis1);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            finish_q <= '0;
        end else begin
            for (int k = 0; k < NUM_FIN; k++) begin
                if (fin_i[k].valid && valid_q[fin_i[k].addr]) begin
                    finish_q[fin_i[k].addr] <= 1'b1;
                end
            end
            if (br_fin_i.valid && valid_q[br_fin_i.addr]) begin
                finish_q[br_fin_i.addr] <= 1'b1;
            end
            // retire committed entries
            if (c0) begin
                valid_q[h0]  <= 1'b0;
                finish_q[h0] <= 1'b0;
            end
            if (c1) begin
                valid_q[h1]  <= 1'b0;
                finish_q[h1] <= 1'b0;
            end
            for (int k = 0; k < 2; k++) begin
                if (dp_we_i[k]) begin
                    valid_q[dp_addr_i[k]]  <= 1'b1;
                    finish_q[dp_addr_i[k]] <= 1'b0;
                end
            end
            if (flush_i) begin
                valid_q  <= '0;
                finish_q <= '0;
            end
        end
    end

    // instruction flags, written at dispatch
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (dp_we_i[k]) begin
                store_q[dp_addr_i[k]]  <= dp_i[k].is_store;
                branch_q[dp_addr_i[k]] <= dp_i[k].is_branch;
                pred_q[dp_addr_i[k]]   <= dp_i[k].pred_taken;
                dstv_q[dp_addr_i[k]]   <= dp_i[k].dst_valid;
            end
        end
        if (br_fin_i.valid && valid_q[br_fin_i.addr]) begin
            taken_q[br_fin_i.addr] <= br_fin_i.taken;
        end
    end

endmodule

// File: common/rob_pkg.sv
// reorder buffer shared definitions
package rob_pkg;

    localparam int ROB_NUM       = 16;
    localparam int ROB_SEL       = 4;
    localparam int ADDR_LEN      = 32;
    localparam int REG_SEL       = 5;
    localparam int BHR_LEN       = 10;
    // alu1, alu2, mul, ldst
    localparam int NUM_FIN       = 4;
    // cycles of blocked dispatch after the flush cycle
    localparam int REFILL_CYCLES = 3;
    localparam int REFILL_W      = $clog2(REFILL_CYCLES + 1);

    typedef logic [ROB_SEL-1:0] rob_ptr_t;

    typedef struct packed {
        logic                valid;
        logic [ADDR_LEN-1:0] pc;
        logic [REG_SEL-1:0]  dst;
        logic                dst_valid;
        logic                is_store;
        logic                is_branch;
        logic                pred_taken;
        logic [BHR_LEN-1:0]  bhr;
    } dp_slot_t;

    // kept per entry until commit
    typedef struct packed {
        logic [ADDR_LEN-1:0] pc;
        logic [REG_SEL-1:0]  dst;
        logic                dst_valid;
        logic [BHR_LEN-1:0]  bhr;
    } dp_payload_t;

    typedef struct packed {
        logic     valid;
        rob_ptr_t addr;
    } fin_t;

    // target is the resolved next fetch address
    typedef struct packed {
        logic                valid;
        rob_ptr_t            addr;
        logic                taken;
        logic [ADDR_LEN-1:0] target;
    } br_fin_t;

    typedef struct packed {
        logic                taken;
        logic [ADDR_LEN-1:0] target;
    } br_payload_t;

    typedef struct packed {
        logic               we;
        logic [REG_SEL-1:0] dst;
    } arf_wr_t;

    typedef struct packed {
        logic                valid;
        logic [ADDR_LEN-1:0] pc;
        logic [BHR_LEN-1:0]  bhr;
        logic                taken;
        logic [ADDR_LEN-1:0] target;
    } br_commit_t;

    typedef struct packed {
        logic                valid;
        logic [ADDR_LEN-1:0] target;
    } redirect_t;

endpackage
